// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_joy_user_port
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/joy_mix.sv
// Pad and USB joystick mixer
`default_nettype none

module joy_mix #(
    parameter int BUTTONS = 2
) (
    input  wire                clk,
    input  wire                rst,
    input  joy_pkg::pad_word_t joy0,
    input  joy_pkg::pad_word_t joy1,
    input  wire                hooked,
    input  wire  [15:0]        usb_joy0,
    input  wire  [15:0]        usb_joy1,
    output logic [15:0]        mix_joy0,
    output logic [15:0]        mix_joy1,
    output logic [5:0]         raw_joy,
    output logic [1:0]         start,
    output logic [1:0]         coin,
    output logic               user_osd
);
    import joy_pkg::*;

    // keeps directions plus the used buttons
    localparam logic [15:0] PAD_MASK = (16'd1 << (BUTTONS + 4)) - 16'd1;

    if (BUTTONS < 1 || BUTTONS > 6) begin : g_bad_buttons
        $error("joy_mix: BUTTONS must be 1 to 6");
    end

    // unused buttons between the last game button and start
    function automatic logic spare_or(pad_word_t w);
        logic acc;
        acc = 1'b0;
        for (int i = 4 + BUTTONS; i < START_BIT; i++) begin
            acc = acc | w[i];
        end
        return acc;
    endfunction

    // ==================================================
    // output registers
    // ==================================================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix_joy0 <= '0;
            mix_joy1 <= '0;
            raw_joy  <= '0;
            start    <= '0;
            coin     <= '0;
            user_osd <= 1'b0;
        end else begin
            mix_joy0 <= ({4'h0, joy0} & PAD_MASK) | usb_joy0;
            mix_joy1 <= ({4'h0, joy1} & PAD_MASK) | usb_joy1;
            // directions and B, C from either pad
            raw_joy  <= joy0[5:0] | joy1[5:0];
            start    <= {joy1[START_BIT], joy0[START_BIT]};
            // a free button doubles as coin when a pad is present
            if (hooked && BUTTONS < 6) begin
                coin <= {joy1[MODE_BIT] | spare_or(joy1), joy0[MODE_BIT] | spare_or(joy0)};
            end else begin
                coin <= {joy1[MODE_BIT], joy0[MODE_BIT]};
            end
            // start plus A on pad 0 opens the menu
            user_osd <= joy0[START_BIT] & joy0[A_BIT];
        end
    end

endmodule

`default_nettype wire

// File: hdl/joy_pkg.sv
// Mega Drive pad adapter definitions
`default_nettype none

package joy_pkg;

    // ==================================================
    // pad word, active high, one per port
    // ==================================================
    typedef logic [11:0] pad_word_t;

    // bit positions inside a pad word
    localparam int UP_BIT    = 0;
    localparam int DN_BIT    = 1;
    localparam int LT_BIT    = 2;
    localparam int RT_BIT    = 3;
    localparam int B_BIT     = 4;
    localparam int C_BIT     = 5;
    localparam int A_BIT     = 6;
    // bits 7 to 9 stay zero on a 3-button pad
    localparam int START_BIT = 10;
    localparam int MODE_BIT  = 11;

    // ==================================================
    // shared pad pins, active low
    // ==================================================
    typedef logic [5:0] pin_bus_t;

    localparam int PIN_UP = 0;
    localparam int PIN_DN = 1;
    // left and right read low when select is low and a pad is present
    localparam int PIN_LT = 2;
    localparam int PIN_RT = 3;
    // TL is B with select high, A with select low
    localparam int PIN_TL = 4;
    // TR is C with select high, start with select low
    localparam int PIN_TR = 5;

    // scan phases, stepped in declaration order
    typedef enum logic [1:0] {
        PH_HI0 = 2'd0,
        PH_LO0 = 2'd1,
        PH_HI1 = 2'd2,
        PH_LO1 = 2'd3
    } scan_phase_e;

    // default scan divider, 2^11 clocks per phase
    localparam int CEN_W_DEF = 11;

endpackage

`default_nettype wire

// File: hdl/joy_user_port.sv
// User port Mega Drive adapter
`default_nettype none

module joy_user_port #(
    parameter int CEN_W   = joy_pkg::CEN_W_DEF,
    parameter int BUTTONS = 2
) (
    input  wire         clk,
    input  wire         rst,
    input  wire  [15:0] usb_joy0,
    input  wire  [15:0] usb_joy1,
    input  wire  [7:0]  user_in,
    output logic [7:0]  user_out,
    output logic [15:0] mix_joy0,
    output logic [15:0] mix_joy1,
    output logic [5:0]  raw_joy,
    output logic [1:0]  start,
    output logic [1:0]  coin,
    output logic        user_osd
);
    import joy_pkg::*;

    logic      cen;
    logic      mdsel;
    logic      split;
    logic      hooked;
    pin_bus_t  pin_bus;
    pad_word_t joy0;
    pad_word_t joy1;

    pad_cap_if cap_if ();

    // ==================================================
    // pin map
    // ==================================================

    // TR, TL, right, left, down, up
    assign pin_bus = {user_in[6], user_in[3], user_in[5], user_in[7], user_in[1], user_in[2]};

    // unused outputs idle high, 8'hEF with select high and split low
    assign user_out = {3'b111, split, 3'b111, mdsel};

    // ==================================================
    // blocks
    // ==================================================

    pad_cen_timer #(
        .CEN_W (CEN_W)
    ) u_timer (
        .clk (clk),
        .rst (rst),
        .cen (cen)
    );

    md_pad_scan u_scan (
        .clk   (clk),
        .rst   (rst),
        .cen   (cen),
        .cap   (cap_if.scan),
        .mdsel (mdsel),
        .split (split)
    );

    md_pad_decode u_decode (
        .clk    (clk),
        .rst    (rst),
        .cap    (cap_if.decode),
        .pins   (pin_bus),
        .joy0   (joy0),
        .joy1   (joy1),
        .hooked (hooked)
    );

    joy_mix #(
        .BUTTONS (BUTTONS)
    ) u_mix (
        .clk      (clk),
        .rst      (rst),
        .joy0     (joy0),
        .joy1     (joy1),
        .hooked   (hooked),
        .usb_joy0 (usb_joy0),
        .usb_joy1 (usb_joy1),
        .mix_joy0 (mix_joy0),
        .mix_joy1 (mix_joy1),
        .raw_joy  (raw_joy),
        .start    (start),
        .coin     (coin),
        .user_osd (user_osd)
    );

endmodule

`default_nettype wire

// File: hdl/md_pad_decode.sv
// Mega Drive pad decoder
`default_nettype none

module md_pad_decode (
    input  wire                clk,
    input  wire                rst,
    pad_cap_if.decode          cap,
    input  joy_pkg::pin_bus_t  pins,
    output joy_pkg::pad_word_t joy0,
    output joy_pkg::pad_word_t joy1,
    output logic               hooked
);
    import joy_pkg::*;

    // staging per pad: six select-high bits, A and start, plugged flag
    logic [1:0][5:0] hi_q;
    logic [1:0][5:0] hi_d;
    logic [1:0][1:0] lo_q;
    logic [1:0][1:0] lo_d;
    logic [1:0]      plug_q;
    logic [1:0]      plug_d;

    pin_bus_t pin_act;
    logic     pad_idx;
    logic     sel_high;

    // buttons read active high from here on
    assign pin_act  = ~pins;
    // phase msb picks the pad, odd phases are select low
    assign pad_idx  = cap.phase[1];
    assign sel_high = (cap.phase == PH_HI0) || (cap.phase == PH_HI1);

    // ==================================================
    // staging update
    // ==================================================

    always_comb begin
        hi_d   = hi_q;
        lo_d   = lo_q;
        plug_d = plug_q;
        if (cap.capture) begin
            if (sel_high) begin
                // up, down, left, right, B, C in pin order
                hi_d[pad_idx] = pin_act;
            end else begin
                // bit 0 A, bit 1 start
                lo_d[pad_idx] = {pin_act[PIN_TR], pin_act[PIN_TL]};
                // a 3-button pad pulls left and right low here
                plug_d[pad_idx] = pin_act[PIN_LT] & pin_act[PIN_RT];
            end
        end
    end

    always_ff @(posedge clk) begin
        hi_q <= hi_d;
        lo_q <= lo_d;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            plug_q <= '0;
        end else begin
            plug_q <= plug_d;
        end
    end

    // ==================================================
    // word assembly
    // ==================================================

    // absent pads publish an all-zero word
    function automatic pad_word_t build_word(logic [5:0] hi, logic [1:0] lo, logic plug);
        pad_word_t w;
        w            = '0;
        w[UP_BIT]    = hi[PIN_UP];
        w[DN_BIT]    = hi[PIN_DN];
        w[LT_BIT]    = hi[PIN_LT];
        w[RT_BIT]    = hi[PIN_RT];
        w[B_BIT]     = hi[PIN_TL];
        w[C_BIT]     = hi[PIN_TR];
        w[A_BIT]     = lo[0];
        w[START_BIT] = lo[1];
        if (!plug) begin
            w = '0;
        end
        return w;
    endfunction

    // built from the next staging so the pad 1 low half
    // captured with publish is already included
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            joy0   <= '0;
            joy1   <= '0;
            hooked <= 1'b0;
        end else if (cap.publish) begin
            joy0   <= build_word(hi_d[0], lo_d[0], plug_d[0]);
            joy1   <= build_word(hi_d[1], lo_d[1], plug_d[1]);
            hooked <= |plug_d;
        end
    end

    // ==================================================
    // checks
    // ==================================================

    // strobes from the scanner only come on the timer enable
    a_capture_cen: assert property (
        @(posedge clk) disable iff (rst)
        cap.capture |-> cap.cen
    );

endmodule

`default_nettype wire

// File: hdl/md_pad_scan.sv
// Mega Drive pad scan FSM
`default_nettype none

module md_pad_scan (
    input  wire            clk,
    input  wire            rst,
    input  wire            cen,
    pad_cap_if.scan        cap,
    output logic           mdsel,
    output logic           split
);
    import joy_pkg::*;

    scan_phase_e phase;
    scan_phase_e phase_nxt;

    // ==================================================
    // phase sequencing
    // ==================================================

    // pad 0 high, pad 0 low, pad 1 high, pad 1 low
    always_comb begin
        case (phase)
            PH_HI0:  phase_nxt = PH_LO0;
            PH_LO0:  phase_nxt = PH_HI1;
            PH_HI1:  phase_nxt = PH_LO1;
            default: phase_nxt = PH_HI0;
        endcase
    end

    // one full cen period per phase
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= PH_HI0;
        end else if (cen) begin
            phase <= phase_nxt;
        end
    end

    // ==================================================
    // bus pins
    // ==================================================

    // select and split follow the phase register,
    // so they move on the cycle after cen
    always_comb begin
        case (phase)
            PH_HI0: begin
                split = 1'b0;
                mdsel = 1'b1;
            end
            PH_LO0: begin
                split = 1'b0;
                mdsel = 1'b0;
            end
            PH_HI1: begin
                split = 1'b1;
                mdsel = 1'b1;
            end
            default: begin
                split = 1'b1;
                mdsel = 1'b0;
            end
        endcase
    end

    // ==================================================
    // capture strobes
    // ==================================================

    // pins have settled for a whole period by the time cen fires,
    // capture carries the phase that is about to end
    assign cap.phase   = phase;
    assign cap.capture = cen;
    // last half-word of the scan, both words are ready
    assign cap.publish = cen && (phase == PH_LO1);
    assign cap.cen     = cen;

    // ==================================================
    // checks
    // ==================================================

    // the phase only steps on the edge that closes a cen cycle
    a_phase_on_cen: assert property (
        @(posedge clk) disable iff (rst)
        (phase != $past(phase)) |-> $past(cen)
    );

endmodule

`default_nettype wire

// File: hdl/pad_cap_if.sv
// Scan to decode capture link
`default_nettype none

interface pad_cap_if;
    import joy_pkg::*;

    // phase that the pins currently answer
    scan_phase_e phase;
    // one-cycle strobe, sample the pins for this phase
    logic        capture;
    // one-cycle strobe, both pad words are complete
    logic        publish;
    // scan enable forwarded for checking
    logic        cen;

    // scanner drives everything
    modport scan (
        output phase,
        output capture,
        output publish,
        output cen
    );

    // decoder always accepts, no back-pressure
    modport decode (
        input phase,
        input capture,
        input publish,
        input cen
    );

endinterface

`default_nettype wire

// File: hdl/pad_cen_timer.sv
// Scan clock enable
`default_nettype none

module pad_cen_timer #(
    parameter int CEN_W = joy_pkg::CEN_W_DEF
) (
    input  wire  clk,
    input  wire  rst,
    output logic cen
);

    // free-running phase counter
    logic [CEN_W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
            cen <= 1'b0;
        end else begin
            // wraps every 2^CEN_W clocks
            cnt <= cnt + CEN_W'(1);
            // one pulse on the all-ones count
            cen <= &cnt;
        end
    end

    // ==================================================
    // checks
    // ==================================================

    // pulse never stretches into a second cycle
    a_cen_single: assert property (
        @(posedge clk) disable iff (rst)
        cen |=> !cen
    );

endmodule

`default_nettype wire

// File: src.f
hdl/joy_pkg.sv
hdl/pad_cap_if.sv
hdl/pad_cen_timer.sv
hdl/md_pad_scan.sv
hdl/md_pad_decode.sv
hdl/joy_mix.sv
hdl/joy_user_port.sv
test/md_pad_model.sv
test/tb_joy_user_port.sv

// File: test/md_pad_model.sv
// Two pad behavioral model
`default_nettype none

module md_pad_model (
    input  wire  [7:0] user_out,
    // per pad: 0 up, 1 down, 2 left, 3 right, 4 B, 5 C, 6 A, 7 start
    input  wire  [7:0] btn0,
    input  wire  [7:0] btn1,
    input  wire  [1:0] plugged,
    output logic [7:0] user_in
);

    logic       sel;
    logic       pad;
    logic       present;
    logic [7:0] btn;
    // pad connector order: up, down, left, right, TL, TR, all active low
    logic [5:0] pins;

    // split picks the port, select picks the half
    assign sel = user_out[0];
    assign pad = user_out[4];

    always_comb begin
        btn     = pad ? btn1 : btn0;
        present = pad ? plugged[1] : plugged[0];
        if (!present) begin
            // pull-ups on an empty port
            pins = 6'h3F;
        end else if (sel) begin
            pins = ~{btn[5], btn[4], btn[3], btn[2], btn[1], btn[0]};
        end else begin
            // left and right forced low, TL is A, TR is start
            pins = ~{btn[7], btn[6], 1'b1, 1'b1, btn[1], btn[0]};
        end
    end

    // user port wiring, spare bits idle high
    always_comb begin
        user_in    = 8'hFF;
        user_in[2] = pins[0];
        user_in[1] = pins[1];
        user_in[7] = pins[2];
        user_in[5] = pins[3];
        user_in[3] = pins[4];
        user_in[6] = pins[5];
    end

endmodule

`default_nettype wire

// File: test/tb_joy_user_port.sv
// User port adapter testbench
`default_nettype none

module tb_joy_user_port;

    localparam int BUTTONS        = 2;
    localparam int PHASE_CYCLES   = 16;
    localparam int SETTLE_CYCLES  = 10 * PHASE_CYCLES;
    localparam int SCAN_RUNS      = 9;
    localparam int ROUNDS         = 30;
    localparam int TIMEOUT_CYCLES = ROUNDS * SETTLE_CYCLES + 1000;

    logic        clk;
    logic        rst;
    logic [15:0] usb_joy0;
    logic [15:0] usb_joy1;
    logic [7:0]  user_in;
    logic [7:0]  user_out;
    logic [15:0] mix_joy0;
    logic [15:0] mix_joy1;
    logic [5:0]  raw_joy;
    logic [1:0]  start;
    logic [1:0]  coin;
    logic        user_osd;
    logic [7:0]  btn0;
    logic [7:0]  btn1;
    logic [1:0]  plugged;
    logic [15:0] lfsr;
    int          cycles;
    int          checks;
    int          value_errs;
    int          other_errs;

    joy_user_port #(
        .CEN_W   (4),
        .BUTTONS (BUTTONS)
    ) dut0 (
        .clk      (clk),
        .rst      (rst),
        .usb_joy0 (usb_joy0),
        .usb_joy1 (usb_joy1),
        .user_in  (user_in),
        .user_out (user_out),
        .mix_joy0 (mix_joy0),
        .mix_joy1 (mix_joy1),
        .raw_joy  (raw_joy),
        .start    (start),
        .coin     (coin),
        .user_osd (user_osd)
    );

    md_pad_model pads0 (
        .user_out (user_out),
        .btn0     (btn0),
        .btn1     (btn1),
        .plugged  (plugged),
        .user_in  (user_in)
    );

    always #2 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ==================================================
    // random source and reference model
    // ==================================================

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // 3-button pad word, start at 10, mode at 11 stays low
    function automatic logic [11:0] pad_word(input logic [7:0] b, input logic plug);
        if (!plug) begin
            return 12'h000;
        end
        return {1'b0, b[7], 3'b000, b[6:0]};
    endfunction

    // directions plus the first BUTTONS buttons of a pad word
    function automatic logic [15:0] used_bits(input logic [11:0] w);
        logic [15:0] m;
        m = '0;
        for (int i = 0; i < BUTTONS + 4; i++) begin
            m[i] = w[i];
        end
        return m;
    endfunction

    // mode bit, plus spare buttons as coin on a hooked port
    function automatic logic coin_bit(input logic [11:0] w, input logic hooked);
        logic c;
        c = w[11];
        if (hooked && BUTTONS < 6) begin
            for (int i = 4 + BUTTONS; i < 10; i++) begin
                c = c | w[i];
            end
        end
        return c;
    endfunction

    function automatic logic [1:0] next_pair(input logic [1:0] p);
        case (p)
            2'b01:   return 2'b00;
            2'b00:   return 2'b11;
            2'b11:   return 2'b10;
            default: return 2'b01;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            value_errs++;
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // ==================================================
    // test steps
    // ==================================================

    task automatic check_reset_state;
        check_value("user_out", {8'h00, user_out}, 16'h00EF);
        check_value("mix_joy0", mix_joy0, 16'h0000);
        check_value("mix_joy1", mix_joy1, 16'h0000);
        check_value("raw_joy", {10'h000, raw_joy}, 16'h0000);
        check_value("start", {14'h0000, start}, 16'h0000);
        check_value("coin", {14'h0000, coin}, 16'h0000);
        check_value("user_osd", {15'h0000, user_osd}, 16'h0000);
    endtask

    // split and select as a pair, first partial phase skipped
    task automatic check_scan_sequence;
        logic [1:0] prev;
        logic [1:0] cur;
        int         run_len;
        int         runs;
        prev    = {user_out[4], user_out[0]};
        run_len = 0;
        runs    = 0;
        while (runs < SCAN_RUNS) begin
            @(negedge clk);
            cur = {user_out[4], user_out[0]};
            if (cur == prev) begin
                run_len++;
            end else begin
                checks++;
                assert (cur == next_pair(prev)) else begin
                    other_errs++;
                    $display("split and select stepped out of order, %b to %b", prev, cur);
                end
                if (runs > 0) begin
                    checks++;
                    assert (run_len == PHASE_CYCLES) else begin
                        other_errs++;
                        $display("scan phase %b lasted %0d cycles instead of %0d",
                                 prev, run_len, PHASE_CYCLES);
                    end
                end
                runs++;
                run_len = 1;
                prev    = cur;
            end
        end
    endtask

    // osd_mode 0 random, 1 forces start and A on pad 0, 2 start without A
    task automatic run_round(input logic [1:0] plug, input int osd_mode);
        logic [31:0] r;
        logic [11:0] w0;
        logic [11:0] w1;
        logic        hk;
        @(negedge clk);
        take_bits(8, r);
        btn0 = r[7:0];
        take_bits(8, r);
        btn1 = r[7:0];
        take_bits(16, r);
        usb_joy0 = r[15:0];
        take_bits(16, r);
        usb_joy1 = r[15:0];
        if (osd_mode == 1) begin
            btn0 = btn0 | 8'hC0;
        end else if (osd_mode == 2) begin
            btn0 = (btn0 | 8'h80) & 8'hBF;
        end
        plugged = plug;
        repeat (SETTLE_CYCLES) @(negedge clk);
        w0 = pad_word(btn0, plug[0]);
        w1 = pad_word(btn1, plug[1]);
        hk = |plug;
        check_value("mix_joy0", mix_joy0, used_bits(w0) | usb_joy0);
        check_value("mix_joy1", mix_joy1, used_bits(w1) | usb_joy1);
        check_value("raw_joy", {10'h000, raw_joy}, {10'h000, w0[5:0] | w1[5:0]});
        check_value("start", {14'h0000, start}, {14'h0000, w1[10], w0[10]});
        check_value("coin", {14'h0000, coin}, {14'h0000, coin_bit(w1, hk), coin_bit(w0, hk)});
        check_value("user_osd", {15'h0000, user_osd}, {15'h0000, w0[10] & w0[6]});
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        usb_joy0   = '0;
        usb_joy1   = '0;
        btn0       = '0;
        btn1       = '0;
        plugged    = '0;
        lfsr       = 16'd29;
        cycles     = 0;
        checks     = 0;
        value_errs = 0;
        other_errs = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        check_scan_sequence();
        // empty ports
        for (int i = 0; i < 4; i++) begin
            run_round(2'b00, 0);
        end
        // both pads present
        for (int i = 0; i < 16; i++) begin
            run_round(2'b11, 0);
        end
        run_round(2'b11, 1);
        run_round(2'b11, 2);
        // one port empty
        for (int i = 0; i < 8; i++) begin
            run_round((i % 2 == 0) ? 2'b01 : 2'b10, 0);
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
